//--- umi_config.svh
`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

// ##########################################################
// umi field widths
// ##########################################################

`define UMI_DW 64 // data width
`define UMI_CW 32 // command width
`define UMI_AW 64 // address width

// ##########################################################
// switch size
// ##########################################################

// N requesters on the input side
`define UMI_N 3

// M output ports, each with its own arbiter and register
`define UMI_M 4

`endif

//--- umi_pkg.sv
`default_nettype none

`include "umi_config.svh"

package umi_pkg;

   // ##########################################################
   // umi fields
   // ##########################################################

   typedef logic [`UMI_CW-1:0] umi_cmd_t;  // opcode, size, len, etc
   typedef logic [`UMI_AW-1:0] umi_addr_t; // dst or src address
   typedef logic [`UMI_DW-1:0] umi_data_t; // write data or read response

   // one full umi transaction, cmd in the top bits
   typedef struct packed
   {
      umi_cmd_t  cmd;
      umi_addr_t dstaddr;
      umi_addr_t srcaddr; // return address for responses
      umi_data_t data;
   } umi_packet_t;

endpackage

`default_nettype wire

//--- arb_pkg.sv
`default_nettype none

`include "umi_config.svh"

package arb_pkg;

   // arbitration scheme, codes 2 and 3 fall back to fixed
   typedef enum logic [1:0]
   {
      arb_fixed       = 2'd0,
      arb_round_robin = 2'd1,
      arb_rsvd2       = 2'd2,
      arb_rsvd3       = 2'd3
   } arb_mode_t;

   typedef logic [`UMI_N-1:0] in_vec_t;  // one bit per input
   typedef logic [`UMI_M-1:0] out_vec_t; // one bit per output

   // input j to output k sits at bit k*N+j
   typedef logic [`UMI_N*`UMI_M-1:0] path_vec_t;

endpackage

`default_nettype wire

//--- umi_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "umi_config.svh"

module umi_arbiter
(
   input  wire logic               clk,
   input  wire logic               arst_n,
   input  wire arb_pkg::arb_mode_t mode,    // fixed or round robin
   input  wire arb_pkg::in_vec_t   req,     // already masked
   input  wire logic               advance, // output register loads this cycle
   output arb_pkg::in_vec_t        grant    // one-hot or zero
);

   import arb_pkg::*;

   in_vec_t last_grant; // one-hot pointer to the last input served
   in_vec_t served_mask; // last_grant and everything below it
   in_vec_t upper_req;   // requests strictly above the pointer
   in_vec_t fixed_grant;
   in_vec_t rr_grant;

   // isolate lowest set bit
   function automatic in_vec_t lowest_bit(input in_vec_t v);
      lowest_bit = v & (~v + 1'b1);
   endfunction

   // ##########################################################
   // grant select
   // ##########################################################

   // lowest index wins
   assign fixed_grant = lowest_bit(req);

   // shift drops the top bit when the pointer is at input N-1,
   // so the mask becomes all ones and the search wraps to 0
   always_comb
   begin
      served_mask = (last_grant << 1) - 1'b1;
      upper_req   = req & ~served_mask;
   end

   always_comb
   begin
      if (|upper_req)
         rr_grant = lowest_bit(upper_req); // next one above pointer
      else
         rr_grant = lowest_bit(req);       // wrap around
   end

   always_comb
   begin
      case (mode)
         arb_round_robin : grant = rr_grant;
         default         : grant = fixed_grant; // fixed and reserved codes
      endcase
   end

   // ##########################################################
   // round robin pointer
   // ##########################################################

   // after reset the pointer sits on the last input,
   // which puts input 0 first in line
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         last_grant <= in_vec_t'(1) << (`UMI_N - 1);
      else if (advance && (mode == arb_round_robin) && (|grant))
         last_grant <= grant;
   end

   // ##########################################################
   // checks
   // ##########################################################

   // at most one winner per cycle
   a_grant_onehot : assert property
      (@(posedge clk) disable iff (!arst_n) $onehot0(grant));

   // no grant without a live request
   a_grant_requested : assert property
      (@(posedge clk) disable iff (!arst_n) (grant & ~req) == '0);

endmodule

`default_nettype wire

//--- umi_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "umi_config.svh"

module umi_port
(
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  wire arb_pkg::arb_mode_t   mode,
   input  wire arb_pkg::in_vec_t     valid,                // requests for this port
   input  wire arb_pkg::in_vec_t     mask,                 // 1 = path disabled
   input  wire umi_pkg::umi_packet_t in_packet [`UMI_N],   // all inputs broadcast
   output arb_pkg::in_vec_t          port_ready,           // per-input ready
   output logic                      out_valid,
   output umi_pkg::umi_packet_t      out_packet,
   input  wire logic                 out_ready
);

   import arb_pkg::*;
   import umi_pkg::*;

   in_vec_t     req;        // masked requests
   in_vec_t     grant;      // one-hot winner
   logic        can_load;   // register empty or draining
   logic        load;       // winner moves into register
   umi_packet_t sel_packet; // winner's packet

   // ##########################################################
   // arbitration
   // ##########################################################

   // a masked request never reaches the arbiter
   assign req = valid & ~mask;

   umi_arbiter umi_arbiter_i
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .mode    (mode),
      .req     (req),
      .advance (load), // pointer moves only on an accepted packet
      .grant   (grant)
   );

   // register frees up when empty or when the consumer takes it now
   assign can_load = ~out_valid | out_ready;
   assign load     = (|grant) & can_load;

   // ##########################################################
   // packet mux
   // ##########################################################

   // one-hot grant lets a plain or-mux do
   always_comb
   begin
      sel_packet = '0;
      for (int j = 0; j < `UMI_N; j++)
      begin
         if (grant[j])
            sel_packet = sel_packet | in_packet[j];
      end
   end

   // ##########################################################
   // output stage
   // ##########################################################

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else if (load)
         out_valid <= 1'b1; // back to back loads keep it high
      else if (out_ready)
         out_valid <= 1'b0; // drained with nothing new
   end

   // payload only
   always_ff @(posedge clk)
   begin
      if (load)
         out_packet <= sel_packet;
   end

   // ##########################################################
   // ready back to inputs
   // ##########################################################

   // high if input j is not asking for us
   // high if input j wins and the register takes it
   // low otherwise, which covers losers, stalls and masked paths
   always_comb
   begin
      for (int j = 0; j < `UMI_N; j++)
         port_ready[j] = ~valid[j] | (grant[j] & can_load);
   end

   // ##########################################################
   // checks
   // ##########################################################

   // a stalled output holds both valid and payload
   a_out_stable : assert property
      (@(posedge clk) disable iff (!arst_n)
       (out_valid && !out_ready) |=> (out_valid && $stable(out_packet)));

endmodule

`default_nettype wire

//--- umi_switch.sv
`timescale 1ns/100ps
`default_nettype none

`include "umi_config.svh"

module umi_switch
(
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  wire arb_pkg::arb_mode_t   arbmode,              // shared by all ports
   input  wire arb_pkg::path_vec_t   arbmask,              // 1 = disable path
   input  wire arb_pkg::path_vec_t   in_valid,             // bit k*N+j is input j to out k
   input  wire umi_pkg::umi_packet_t in_packet [`UMI_N],
   output arb_pkg::in_vec_t          in_ready,
   output wire arb_pkg::out_vec_t    out_valid,
   output wire umi_pkg::umi_packet_t out_packet [`UMI_M],
   input  wire arb_pkg::out_vec_t    out_ready
);

   import arb_pkg::*;

   in_vec_t  port_ready [`UMI_M]; // ready of every port toward every input
   out_vec_t in_dest [`UMI_N];    // valids regrouped per input

   // ##########################################################
   // output ports
   // ##########################################################

   // packets broadcast to every port while valids and mask are sliced per port
   for (genvar k = 0; k < `UMI_M; k++)
   begin : gen_port
      umi_port umi_port_i
      (
         .clk        (clk),
         .arst_n     (arst_n),
         .mode       (arbmode),
         .valid      (in_valid[k*`UMI_N +: `UMI_N]),
         .mask       (arbmask[k*`UMI_N +: `UMI_N]),
         .in_packet  (in_packet),
         .port_ready (port_ready[k]),
         .out_valid  (out_valid[k]),
         .out_packet (out_packet[k]),
         .out_ready  (out_ready[k])
      );
   end

   // ##########################################################
   // ready merge
   // ##########################################################

   // every port must agree, which only works for unicast
   always_comb
   begin
      in_ready = '1;
      for (int k = 0; k < `UMI_M; k++)
         in_ready = in_ready & port_ready[k];
   end

   // ##########################################################
   // checks
   // ##########################################################

   always_comb
   begin
      for (int j = 0; j < `UMI_N; j++)
         for (int k = 0; k < `UMI_M; k++)
            in_dest[j][k] = in_valid[k*`UMI_N + j];
   end

   for (genvar j = 0; j < `UMI_N; j++)
   begin : gen_chk
      // at most one destination per input
      a_in_onehot : assert property
         (@(posedge clk) disable iff (!arst_n) $onehot0(in_dest[j]));
   end

endmodule

`default_nettype wire

//--- tb_umi_vectors.svh
`ifndef TB_UMI_VECTORS_SVH
`define TB_UMI_VECTORS_SVH

// what the monitor expects on the watched output
typedef enum logic [1:0]
{
   ord_none,      // queue order only
   ord_ascending, // lowest index first, back to back
   ord_alternate, // rotate past last winner, back to back
   ord_parallel   // all inputs accepted at once, out one cycle later
} order_rule_t;

typedef struct packed
{
   arb_mode_t              mode;
   path_vec_t              mask;
   logic [`UMI_N-1:0][1:0] dest;         // target output per input
   logic [`UMI_N-1:0][3:0] count;        // packets per input, 0 = idle
   logic                   backpressure; // random out_ready
   order_rule_t            rule;
   logic [1:0]             watch;        // output the order rule looks at
   logic [1:0]             first;        // expected first winner there
   logic [1:0]             stall;        // input on a masked path, 3 = none
} vec_row_t;

localparam int num_rows = 6;

vec_row_t vec_table [num_rows];

function automatic vec_row_t make_row(input arb_mode_t mode, input path_vec_t mask,
                                      input logic [`UMI_N-1:0][1:0] dest,
                                      input logic [`UMI_N-1:0][3:0] count,
                                      input logic bp, input order_rule_t rule,
                                      input logic [1:0] watch, input logic [1:0] first,
                                      input logic [1:0] stall);
   vec_row_t row;
   row.mode         = mode;
   row.mask         = mask;
   row.dest         = dest;
   row.count        = count;
   row.backpressure = bp;
   row.rule         = rule;
   row.watch        = watch;
   row.first        = first;
   row.stall        = stall;
   return row;
endfunction

// per-input lists run input 2 down to input 0
task automatic load_table();
   // single packet, in0 to out0
   vec_table[0] = make_row(arb_fixed, '0, {2'd0, 2'd0, 2'd0}, {4'd0, 4'd0, 4'd1},
                           1'b0, ord_parallel, 2'd0, 2'd0, 2'd3);
   // everyone at out2
   vec_table[1] = make_row(arb_fixed, '0, {2'd2, 2'd2, 2'd2}, {4'd1, 4'd1, 4'd1},
                           1'b0, ord_ascending, 2'd2, 2'd0, 2'd3);
   // in0 and in2 share out1
   vec_table[2] = make_row(arb_round_robin, '0, {2'd1, 2'd0, 2'd1}, {4'd4, 4'd0, 4'd4},
                           1'b0, ord_alternate, 2'd1, 2'd0, 2'd3);
   // in0 to out3, in1 to out0, in2 to out1
   vec_table[3] = make_row(arb_fixed, '0, {2'd1, 2'd0, 2'd3}, {4'd1, 4'd1, 4'd1},
                           1'b0, ord_parallel, 2'd0, 2'd0, 2'd3);
   // random stalls on every port
   vec_table[4] = make_row(arb_round_robin, '0, {2'd3, 2'd1, 2'd1}, {4'd8, 4'd8, 4'd8},
                           1'b1, ord_none, 2'd0, 2'd0, 2'd3);
   // in1 to out0 masked, reserved code acts as fixed
   vec_table[5] = make_row(arb_rsvd2, path_vec_t'(1) << 1, {2'd0, 2'd0, 2'd0},
                           {4'd0, 4'd1, 4'd4}, 1'b0, ord_none, 2'd0, 2'd0, 2'd1);
endtask

`endif

//--- tb_umi_switch.sv
`timescale 1ns/100ps
`default_nettype none

`include "umi_config.svh"

module tb_umi_switch;

   import arb_pkg::*;
   import umi_pkg::*;

   `include "tb_umi_vectors.svh"

   localparam int wait_limit   = 200; // cycles per wait
   localparam int stall_cycles = 20;  // masked input watch window

   logic        clk;
   logic        arst_n;
   arb_mode_t   arbmode;
   path_vec_t   arbmask;
   path_vec_t   in_valid;
   umi_packet_t in_packet [`UMI_N];
   in_vec_t     in_ready;
   out_vec_t    out_valid;
   umi_packet_t out_packet [`UMI_M];
   out_vec_t    out_ready;

   umi_packet_t sb [`UMI_M][$];  // expected packets per output in order
   int          got_count [`UMI_M];
   int          remaining [`UMI_N]; // packets left per input for the order model
   int          prev_src;           // last source seen on watched port
   logic        in_burst;           // watched port must stay busy
   vec_row_t    cur_row;
   int          cur_idx;
   logic        bp_on;
   integer      seed;
   int          busy;               // input drivers still running

   umi_switch umi_switch_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .arbmode    (arbmode),
      .arbmask    (arbmask),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns
   end

   // consumer drives a new ready 1 ns after each edge
   initial
   begin
      forever
      begin
         @(posedge clk);
         #1;
         if (bp_on)
            out_ready = out_vec_t'($random(seed));
         else
            out_ready = '1;
      end
   end

   // ##########################################################
   // helpers and checks
   // ##########################################################

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_packet(input umi_packet_t got, input umi_packet_t exp,
                               input string what);
      if (got !== exp)
         stop_run($sformatf("[FAIL] %0t: %s, got %h/%h/%h/%h expected %h/%h/%h/%h",
                            $time, what, got.cmd, got.dstaddr, got.srcaddr, got.data,
                            exp.cmd, exp.dstaddr, exp.srcaddr, exp.data));
   endtask

   task automatic check_ready(input in_vec_t got, input in_vec_t exp, input string what);
      if (got !== exp)
         stop_run($sformatf("[FAIL] %0t: %s, in_ready %b expected %b",
                            $time, what, got, exp));
   endtask

   task automatic check_valid(input out_vec_t got, input out_vec_t exp, input string what);
      if (got !== exp)
         stop_run($sformatf("[FAIL] %0t: %s, out_valid %b expected %b",
                            $time, what, got, exp));
   endtask

   // data = input, dest, row, sequence
   function automatic umi_packet_t make_packet(input int j, input int seq, input int dest,
                                               input int r);
      umi_packet_t pkt;
      pkt.cmd     = umi_cmd_t'(32'h0400_0000 + (r << 16) + (j << 8) + seq);
      pkt.dstaddr = umi_addr_t'(64'h0000_00a0_0000_0000) + umi_addr_t'((dest << 20) + seq);
      pkt.srcaddr = umi_addr_t'(64'h0000_00c0_0000_0000) + umi_addr_t'((j << 20) + seq);
      pkt.data    = {8'(j), 8'(dest), 16'(r), 32'(seq)};
      return pkt;
   endfunction

   function automatic int pending();
      int total;
      total = 0;
      for (int k = 0; k < `UMI_M; k++)
         total += sb[k].size();
      return total;
   endfunction

   // next winner by the row's rule or -1 when nothing is left
   function automatic int next_source();
      int cand;
      if (prev_src < 0)
         return cur_row.first;
      for (int step = 1; step <= `UMI_N; step++)
      begin
         if (cur_row.rule == ord_ascending)
            cand = step - 1;                      // lowest index first
         else
            cand = (prev_src + step) % `UMI_N;    // past the last winner
         if (remaining[cand] > 0)
            return cand;
      end
      return -1;
   endfunction

   task automatic check_order(input int k);
      int src;
      src = next_source();
      if (src < 0)
         stop_run($sformatf("output %0d sent more packets than the row holds", k));
      else
      begin
         check_packet(out_packet[k],
                      make_packet(src, cur_row.count[src] - remaining[src], k, cur_idx),
                      "arbitration order");
         remaining[src]--;
         prev_src = src;
         in_burst = 1'b0;
         for (int j = 0; j < `UMI_N; j++)
            if (remaining[j] > 0)
               in_burst = 1'b1;
      end
   endtask

   // ##########################################################
   // input drivers
   // ##########################################################

   task automatic drive_input(input int j);
      umi_packet_t pkt;
      int          k;
      int          s;
      int          waited;
      int          expect_got;
      k = cur_row.dest[j];
      if (cur_row.count[j] == 0)
         return;
      if (cur_row.stall == j)
      begin
         // the masked path never answers this request
         in_packet[j] = make_packet(j, 0, k, cur_idx);
         in_valid[k*`UMI_N + j] = 1'b1;
         for (s = 0; s < stall_cycles; s++)
         begin
            @(negedge clk);
            check_ready(in_ready & (in_vec_t'(1) << j), '0, "masked input");
         end
         expect_got = 0; // other traffic to this output passed meanwhile
         for (int i = 0; i < `UMI_N; i++)
            if (i != j && cur_row.dest[i] == k)
               expect_got += cur_row.count[i];
         if (got_count[k] != expect_got)
            stop_run($sformatf("[FAIL] %0t: output %0d delivered %0d of %0d packets %s",
                               $time, k, got_count[k], expect_got, "during the stall"));
         @(posedge clk);
         #1;
         in_valid[k*`UMI_N + j] = 1'b0;
         return;
      end
      for (s = 0; s < cur_row.count[j]; s++)
      begin
         pkt = make_packet(j, s, k, cur_idx);
         in_packet[j] = pkt;
         in_valid[k*`UMI_N + j] = 1'b1; // held until accepted
         waited = 0;
         @(negedge clk);
         while (!in_ready[j])
         begin
            waited++;
            if (waited > wait_limit)
               stop_run($sformatf("timeout: input %0d never accepted packet %0d", j, s));
            @(negedge clk);
         end
         sb[k].push_back(pkt); // taken at the coming edge
         @(posedge clk);
         #1;
      end
      in_valid[k*`UMI_N + j] = 1'b0;
   endtask

   // ##########################################################
   // output monitor
   // ##########################################################

   initial
   begin
      umi_packet_t held [`UMI_M];
      out_vec_t    held_valid;
      out_vec_t    wbit;
      held_valid = '0;
      forever
      begin
         @(negedge clk);
         wbit = out_vec_t'(1) << cur_row.watch;
         if (in_burst)
            check_valid(out_valid & wbit, wbit, "back to back output");
         for (int k = 0; k < `UMI_M; k++)
         begin
            if (held_valid[k])
            begin
               // stalled last cycle so still there and unchanged
               check_valid(out_valid & (out_vec_t'(1) << k), out_vec_t'(1) << k, "stall");
               check_packet(out_packet[k], held[k], "stalled output");
            end
            held_valid[k] = out_valid[k] & ~out_ready[k];
            held[k]       = out_packet[k];
            if (out_valid[k] && out_ready[k])
            begin
               if (sb[k].size() == 0)
                  stop_run($sformatf("output %0d delivered a packet nobody sent", k));
               check_packet(out_packet[k], sb[k].pop_front(), "scoreboard");
               got_count[k]++;
               if (k == cur_row.watch &&
                   (cur_row.rule == ord_ascending || cur_row.rule == ord_alternate))
                  check_order(k);
            end
         end
      end
   end

   // ##########################################################
   // main sequence
   // ##########################################################

   initial
   begin
      int       waited;
      out_vec_t exp_valid;
      $timeformat(-9, 1, " ns", 10);
      seed       = 32'hb9eb;
      bp_on      = 1'b0;
      busy       = 0;
      arst_n     = 1'b0;
      arbmode    = arb_fixed;
      arbmask    = '0;
      in_valid   = '0;
      out_ready  = '1;
      for (int j = 0; j < `UMI_N; j++)
         in_packet[j] = '0;
      cur_row  = '0;
      cur_idx  = 0;
      prev_src = -1;
      in_burst = 1'b0;
      load_table();
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_valid(out_valid, '0, "after reset");
      check_ready(in_ready, '1, "idle inputs");
      @(posedge clk);
      #1;
      for (int r = 0; r < num_rows; r++)
      begin
         cur_row   = vec_table[r];
         cur_idx   = r;
         arbmode   = cur_row.mode;   // valids are all low here
         arbmask   = cur_row.mask;
         bp_on     = cur_row.backpressure;
         prev_src  = -1;
         in_burst  = 1'b0;
         exp_valid = '0;
         for (int j = 0; j < `UMI_N; j++)
         begin
            remaining[j] = (cur_row.dest[j] == cur_row.watch) ? cur_row.count[j] : 0;
            if (cur_row.count[j] != 0)
               exp_valid[cur_row.dest[j]] = 1'b1;
         end
         for (int k = 0; k < `UMI_M; k++)
            got_count[k] = 0;
         @(posedge clk);
         #1;
         busy = `UMI_N;
         for (int j = 0; j < `UMI_N; j++)
         begin
            fork
               automatic int jj = j;
               begin
                  drive_input(jj);
                  busy--;
               end
            join_none
         end
         if (cur_row.rule == ord_parallel)
         begin
            @(negedge clk);
            check_ready(in_ready, '1, "parallel accept");
            @(negedge clk);
            check_valid(out_valid, exp_valid, "one cycle latency");
         end
         waited = 0;
         while (busy != 0)
         begin
            waited++;
            if (waited > wait_limit)
               stop_run("timeout: input drivers did not finish the row");
            @(negedge clk);
         end
         bp_on  = 1'b0;
         waited = 0;
         while (pending() != 0)
         begin
            waited++;
            if (waited > wait_limit)
               stop_run("timeout: packets still queued after the row finished");
            @(negedge clk);
         end
         @(posedge clk);
         #1;
      end
      @(negedge clk);
      check_valid(out_valid, '0, "idle at end");
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
umi_pkg.sv
arb_pkg.sv
umi_arbiter.sv
umi_port.sv
umi_switch.sv
tb_umi_switch.sv
